// ==== hdl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	// Major opcodes used by RV32I
	typedef enum logic [6:0] {
		opOp     = 7'b0110011,
		opOpImm  = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opSystem = 7'b1110011
	} opcodeT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeT     opcode;
	} sTypeT;

	typedef struct packed {
		logic       immSign; // imm[12]
		logic [5:0] immHi;   // imm[10:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;   // imm[4:1]
		logic       imm11;
		opcodeT     opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcodeT      opcode;
	} uTypeT;

	typedef struct packed {
		logic       immSign; // imm[20]
		logic [9:0] immLo;   // imm[10:1]
		logic       imm11;
		logic [7:0] immHi;   // imm[19:12]
		logic [4:0] rd;
		opcodeT     opcode;
	} jTypeT;

	// One instruction word, six views
	typedef union packed {
		rTypeT r;
		iTypeT i;
		sTypeT s;
		bTypeT b;
		uTypeT u;
		jTypeT j;
	} instrU;

	// Branch kinds
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// Load and store widths
	localparam logic [2:0] f3Byte  = 3'b000;
	localparam logic [2:0] f3Half  = 3'b001;
	localparam logic [2:0] f3Word  = 3'b010;
	localparam logic [2:0] f3ByteU = 3'b100;
	localparam logic [2:0] f3HalfU = 3'b101;

	// ALU selections for OP and OP-IMM
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	localparam logic [6:0] f7Alt = 7'b0100000; // SUB and SRA

	localparam logic [31:0] ebreakWord = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== hdl/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

	localparam int xlen  = 32;
	localparam int addrW = 12; // memory address bits

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpT;

	typedef enum logic {aRs1, aPc} aSelT;
	typedef enum logic {bRs2, bImm} bSelT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

	// Access sizes as carried in memSize
	localparam logic [1:0] szByte = 2'd0;
	localparam logic [1:0] szHalf = 2'd1;
	localparam logic [1:0] szWord = 2'd2;

	typedef struct packed {
		aluOpT      aluOp;
		aSelT       aSel;
		bSelT       bSel;
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		logic [1:0] memSize;
		logic       memUnsigned;
		wbSelT      wbSel;
		logic       isBranch;
		logic [2:0] branchKind;
		logic       isJal;
		logic       isJalr;
		logic       isHalt;
	} ctrlT;

endpackage

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
	input  rvIsaPkg::instrU             instr,
	input  logic                        active,
	output rvCorePkg::ctrlT             ctrl,
	output logic [rvCorePkg::xlen-1:0]  imm,
	output logic [4:0]                  rs1,
	output logic [4:0]                  rs2,
	output logic [4:0]                  rd
);
	import rvIsaPkg::*;
	import rvCorePkg::*;

	opcodeT     opcode;
	logic [2:0] funct3;
	logic       alt;
	ctrlT       raw;

	function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic altBit,
			input logic isReg);
		case (f3)
			f3AddSub: return (isReg && altBit) ? aluSub : aluAdd;
			f3Sll:    return aluSll;
			f3Slt:    return aluSlt;
			f3Sltu:   return aluSltu;
			f3Xor:    return aluXor;
			f3SrlSra: return altBit ? aluSra : aluSrl;
			f3Or:     return aluOr;
			f3And:    return aluAnd;
			default:  return aluAdd;
		endcase
	endfunction

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign alt    = (instr.r.funct7 == f7Alt); // Also imm[11:5] of SRAI
	assign rs1    = instr.r.rs1;
	assign rs2    = instr.r.rs2;
	assign rd     = instr.r.rd;

	// Immediate format follows the opcode
	always_comb begin
		case (opcode)
			opOpImm, opLoad, opJalr: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			opStore:  imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
			opBranch: imm = {{19{instr.b.immSign}}, instr.b.immSign, instr.b.imm11,
					instr.b.immHi, instr.b.immLo, 1'b0};
			opLui, opAuipc: imm = {instr.u.imm, 12'h000};
			opJal:    imm = {{11{instr.j.immSign}}, instr.j.immSign, instr.j.immHi,
					instr.j.imm11, instr.j.immLo, 1'b0};
			default:  imm = '0;
		endcase
	end

	always_comb begin
		raw             = '0;
		raw.aluOp       = aluAdd;
		raw.aSel        = aRs1;
		raw.bSel        = bRs2;
		raw.wbSel       = wbAlu;
		raw.memSize     = funct3[1:0];
		raw.memUnsigned = funct3[2];
		raw.branchKind  = funct3;
		case (opcode)
			opOp: begin
				raw.aluOp    = aluFromFunct(funct3, alt, 1'b1);
				raw.regWrite = 1'b1;
			end
			opOpImm: begin
				raw.aluOp    = aluFromFunct(funct3, alt, 1'b0);
				raw.bSel     = bImm;
				raw.regWrite = 1'b1;
			end
			opLui: begin
				raw.aluOp    = aluPassB;
				raw.bSel     = bImm;
				raw.regWrite = 1'b1;
			end
			opAuipc: begin
				raw.aSel     = aPc;
				raw.bSel     = bImm;
				raw.regWrite = 1'b1;
			end
			opJal: begin
				raw.isJal    = 1'b1;
				raw.regWrite = 1'b1;
				raw.wbSel    = wbLink;
			end
			opJalr: begin
				raw.bSel     = bImm; // Target rs1+imm from the ALU
				raw.isJalr   = 1'b1;
				raw.regWrite = 1'b1;
				raw.wbSel    = wbLink;
			end
			opBranch: begin
				raw.aluOp = aluSub;
				case (funct3)
					f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu: raw.isBranch = 1'b1;
					default: raw.isBranch = 1'b0;
				endcase
			end
			opLoad: begin
				raw.bSel = bImm;
				case (funct3)
					f3Byte, f3Half, f3Word, f3ByteU, f3HalfU: begin
						raw.memRead  = 1'b1;
						raw.regWrite = 1'b1;
						raw.wbSel    = wbMem;
					end
					default: raw.memRead = 1'b0;
				endcase
			end
			opStore: begin
				raw.bSel = bImm;
				case (funct3)
					f3Byte, f3Half, f3Word: raw.memWrite = 1'b1;
					default: raw.memWrite = 1'b0;
				endcase
			end
			opSystem: raw.isHalt = (instr == ebreakWord); // Only EBREAK
			default: raw.regWrite = 1'b0; // Unknown opcode runs as a no-op
		endcase
	end

	// No side effects while idle, x0 never written
	always_comb begin
		ctrl          = raw;
		ctrl.regWrite = raw.regWrite & active & (rd != 5'd0);
		ctrl.memWrite = raw.memWrite & active;
		ctrl.memRead  = raw.memRead & active;
	end

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`default_nettype none

module aluUnit (
	input  logic [rvCorePkg::xlen-1:0] a,
	input  logic [rvCorePkg::xlen-1:0] b,
	input  rvCorePkg::aluOpT           op,
	output logic [rvCorePkg::xlen-1:0] result,
	output logic                       eq,
	output logic                       lt,
	output logic                       ltu
);
	import rvCorePkg::*;

	logic [xlen:0] diff; // Extra bit holds the unsigned borrow
	logic [4:0]    shamt;

	assign diff  = {1'b0, a} - {1'b0, b};
	assign shamt = b[4:0];

	// Flags come from the one subtractor
	assign ltu = diff[xlen];
	assign eq  = (diff[xlen-1:0] == '0);
	assign lt  = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : diff[xlen-1];

	always_comb begin
		case (op)
			aluAdd:   result = a + b;
			aluSub:   result = diff[xlen-1:0];
			aluSll:   result = a << shamt;
			aluSlt:   result = {{(xlen-1){1'b0}}, lt};
			aluSltu:  result = {{(xlen-1){1'b0}}, ltu};
			aluXor:   result = a ^ b;
			aluSrl:   result = a >> shamt;
			aluSra:   result = $signed(a) >>> shamt;
			aluOr:    result = a | b;
			aluAnd:   result = a & b;
			aluPassB: result = b; // LUI
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/pcState.sv ====
`default_nettype none

module pcState (
	input  logic                        CLK,
	input  logic                        RSTn,
	input  logic [rvCorePkg::addrW-1:0] nextPc,
	input  logic                        haltReq,
	output logic [rvCorePkg::addrW-1:0] pc,
	output logic                        active,
	output logic                        halt,
	output logic [31:0]                 numInst
);

	logic running; // Set one edge after reset is released

	assign active = running & ~halt;

	// RSTn is asserted high here
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= '0;
			numInst <= '0;
			halt    <= 1'b0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (active) begin
				pc      <= nextPc;
				numInst <= numInst + 32'd1; // EBREAK counts as retired
				halt    <= haltReq;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/nextPcLogic.sv ====
`default_nettype none

module nextPcLogic (
	input  logic [rvCorePkg::addrW-1:0] pc,
	input  rvCorePkg::ctrlT             ctrl,
	input  logic [rvCorePkg::xlen-1:0]  imm,
	input  logic [rvCorePkg::xlen-1:0]  aluResult,
	input  logic                        eq,
	input  logic                        lt,
	input  logic                        ltu,
	output logic [rvCorePkg::addrW-1:0] nextPc,
	output logic [rvCorePkg::xlen-1:0]  linkVal,
	output logic                        haltReq
);
	import rvIsaPkg::*;
	import rvCorePkg::*;

	logic             taken;
	logic [addrW-1:0] seqPc;
	logic [addrW-1:0] relPc;
	logic [addrW-1:0] jalrPc;

	always_comb begin
		case (ctrl.branchKind)
			f3Beq:   taken = eq;
			f3Bne:   taken = ~eq;
			f3Blt:   taken = lt;
			f3Bge:   taken = ~lt;
			f3Bltu:  taken = ltu;
			f3Bgeu:  taken = ~ltu;
			default: taken = 1'b0;
		endcase
	end

	assign seqPc  = pc + addrW'(4);
	assign relPc  = pc + imm[addrW-1:0];                // JAL and branches
	assign jalrPc = {aluResult[addrW-1:1], 1'b0};

	always_comb begin
		if (ctrl.isHalt) nextPc = pc; // Park on the EBREAK
		else if (ctrl.isJalr) nextPc = jalrPc;
		else if (ctrl.isJal || (ctrl.isBranch && taken)) nextPc = relPc;
		else nextPc = seqPc;
	end

	assign linkVal = {{(xlen-addrW){1'b0}}, seqPc};
	assign haltReq = ctrl.isHalt;

endmodule

`default_nettype wire

// ==== hdl/lsuAlign.sv ====
`default_nettype none

module lsuAlign (
	input  rvCorePkg::ctrlT             ctrl,
	input  logic [rvCorePkg::xlen-1:0]  addr,
	input  logic [rvCorePkg::xlen-1:0]  storeData,
	input  logic [rvCorePkg::xlen-1:0]  memRd,
	input  logic [rvCorePkg::xlen-1:0]  aluResult,
	input  logic [rvCorePkg::xlen-1:0]  linkVal,
	output logic [rvCorePkg::addrW-1:0] wordAddr,
	output logic [3:0]                  be,
	output logic [rvCorePkg::xlen-1:0]  memWd,
	output logic                        csn,
	output logic                        wen,
	output logic [rvCorePkg::xlen-1:0]  rfWd
);
	import rvCorePkg::*;

	logic [1:0]      lane;
	logic [xlen-1:0] shifted; // Addressed byte moved to lane 0
	logic [xlen-1:0] loadVal;

	assign lane     = addr[1:0];
	assign wordAddr = addr[addrW+1:2];
	assign csn      = ~(ctrl.memRead | ctrl.memWrite);
	assign wen      = ~ctrl.memWrite; // Active low

	// Store data copied to every lane, enables pick the bytes
	always_comb begin
		case (ctrl.memSize)
			szByte: begin
				memWd = {4{storeData[7:0]}};
				be    = 4'b0001 << lane;
			end
			szHalf: begin
				memWd = {2{storeData[15:0]}};
				be    = 4'b0011 << {lane[1], 1'b0};
			end
			szWord: begin
				memWd = storeData;
				be    = 4'b1111;
			end
			default: begin
				memWd = storeData;
				be    = 4'b0000;
			end
		endcase
	end

	assign shifted = memRd >> {lane, 3'b000};

	always_comb begin
		case (ctrl.memSize)
			szByte: loadVal = ctrl.memUnsigned ? {24'h0, shifted[7:0]}
					: {{24{shifted[7]}}, shifted[7:0]};
			szHalf: loadVal = ctrl.memUnsigned ? {16'h0, shifted[15:0]}
					: {{16{shifted[15]}}, shifted[15:0]};
			default: loadVal = memRd;
		endcase
	end

	// Writeback select
	always_comb begin
		case (ctrl.wbSel)
			wbMem:   rfWd = loadVal;
			wbLink:  rfWd = linkVal;
			default: rfWd = aluResult;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/RISCV_TOP.sv ====
`default_nettype none

module RISCV_TOP (
	input  logic                        CLK,
	input  logic                        RSTn,

	// Instruction memory
	output logic                        iMemCsn,
	input  logic [31:0]                 iMemDi,
	output logic [rvCorePkg::addrW-1:0] iMemAddr, // Byte address

	// Data memory
	output logic                        dMemCsn,
	input  logic [31:0]                 dMemDi,
	output logic [31:0]                 dMemDout,
	output logic [rvCorePkg::addrW-1:0] dMemAddr, // Word address
	output logic                        dMemWen,
	output logic [3:0]                  dMemBe,

	// Register file
	output logic                        rfWe,
	output logic [4:0]                  rfRa1,
	output logic [4:0]                  rfRa2,
	output logic [4:0]                  rfWa,
	input  logic [31:0]                 rfRd1,
	input  logic [31:0]                 rfRd2,
	output logic [31:0]                 rfWd,

	output logic                        halt,
	output logic [31:0]                 numInst // Retired instructions
);
	import rvCorePkg::*;

	ctrlT             ctrl;
	logic [xlen-1:0]  imm;
	logic [xlen-1:0]  aluA;
	logic [xlen-1:0]  aluB;
	logic [xlen-1:0]  aluResult;
	logic [xlen-1:0]  linkVal;
	logic             eq;
	logic             lt;
	logic             ltu;
	logic [addrW-1:0] pc;
	logic [addrW-1:0] nextPc;
	logic             active;
	logic             haltReq;

	assign iMemAddr = pc;
	assign iMemCsn  = ~active;
	assign rfWe     = ctrl.regWrite;

	// Operand selects
	assign aluA = (ctrl.aSel == aPc) ? {{(xlen-addrW){1'b0}}, pc} : rfRd1;
	assign aluB = (ctrl.bSel == bImm) ? imm : rfRd2;

	pcState pcStateInst (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.nextPc  (nextPc),
		.haltReq (haltReq),
		.pc      (pc),
		.active  (active),
		.halt    (halt),
		.numInst (numInst)
	);

	instrDecoder instrDecoderInst (
		.instr  (iMemDi), // Raw word viewed as the format union
		.active (active),
		.ctrl   (ctrl),
		.imm    (imm),
		.rs1    (rfRa1),
		.rs2    (rfRa2),
		.rd     (rfWa)
	);

	aluUnit aluUnitInst (
		.a      (aluA),
		.b      (aluB),
		.op     (ctrl.aluOp),
		.result (aluResult),
		.eq     (eq),
		.lt     (lt),
		.ltu    (ltu)
	);

	nextPcLogic nextPcLogicInst (
		.pc        (pc),
		.ctrl      (ctrl),
		.imm       (imm),
		.aluResult (aluResult),
		.eq        (eq),
		.lt        (lt),
		.ltu       (ltu),
		.nextPc    (nextPc),
		.linkVal   (linkVal),
		.haltReq   (haltReq)
	);

	lsuAlign lsuAlignInst (
		.ctrl      (ctrl),
		.addr      (aluResult),
		.storeData (rfRd2),
		.memRd     (dMemDi),
		.aluResult (aluResult),
		.linkVal   (linkVal),
		.wordAddr  (dMemAddr),
		.be        (dMemBe),
		.memWd     (dMemDout),
		.csn       (dMemCsn),
		.wen       (dMemWen),
		.rfWd      (rfWd)
	);

endmodule

`default_nettype wire

// ==== dv/riscvTopTb.sv ====
`default_nettype none

module riscvTopTb;

	logic        CLK = 1'b0;
	logic        RSTn;
	logic        iMemCsn;
	logic [31:0] iMemDi;
	logic [11:0] iMemAddr;
	logic        dMemCsn;
	logic [31:0] dMemDi;
	logic [31:0] dMemDout;
	logic [11:0] dMemAddr;
	logic        dMemWen;
	logic [3:0]  dMemBe;
	logic        rfWe;
	logic [4:0]  rfRa1;
	logic [4:0]  rfRa2;
	logic [4:0]  rfWa;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic [31:0] rfWd;
	logic        halt;
	logic [31:0] numInst;

	logic [31:0] imem [0:1023];
	logic [31:0] dmem [0:4095];
	logic [31:0] rf [0:31];
	logic [4:0]  wbRd [$]; // Expected writebacks in order
	logic [31:0] wbVal [$];
	logic [4:0]  finRd [$]; // Expected final registers
	logic [31:0] finVal [$];
	logic [31:0] expCount;
	logic [31:0] cycleLimit = 32'hFFFF_FFFF;
	logic [31:0] cycles = 0;
	int          wbIdx = 0;
	int          wbErrs = 0;
	int          loadErrs = 0;
	int          passed = 0;
	int          failed = 0;

	RISCV_TOP RISCV_TOP_inst (.*);

	always #4 CLK = ~CLK;

	// Combinational memories and register file
	assign iMemDi = imem[iMemAddr[11:2]];
	assign dMemDi = dmem[dMemAddr];
	assign rfRd1  = (rfRa1 == 5'd0) ? 32'd0 : rf[rfRa1];
	assign rfRd2  = (rfRa2 == 5'd0) ? 32'd0 : rf[rfRa2];

	always @(posedge CLK) begin
		cycles <= cycles + 32'd1;
		if (!dMemCsn && !dMemWen) begin
			for (int b = 0; b < 4; b++)
				if (dMemBe[b]) dmem[dMemAddr][b*8 +: 8] <= dMemDout[b*8 +: 8];
		end
		if (rfWe) begin
			if (rfWa != 5'd0) rf[rfWa] <= rfWd;
			if (wbIdx >= wbRd.size()) begin
				$display("Unexpected extra writeback to x%0d at time %0t", rfWa, $time);
				wbErrs++;
			end else if (rfWa != wbRd[wbIdx] || rfWd != wbVal[wbIdx]) begin
				$display("[ERROR] %0t: writeback %0d expected x%0d=%h, got x%0d=%h", $time,
					wbIdx, wbRd[wbIdx], wbVal[wbIdx], rfWa, rfWd);
				if (iMemDi[6:0] == 7'b0000011) loadErrs++; // Load instruction
				else wbErrs++;
			end
			wbIdx++;
		end
	end

	// Watchdog
	always @(posedge CLK) begin
		if (cycles >= cycleLimit) begin
			$display("Timeout: core did not halt within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic readTrace;
		int          fd;
		int          code;
		byte         kind;
		string       line;
		logic [31:0] a;
		logic [31:0] v;
		fd = $fopen("dv/programTrace.mem", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file dv/programTrace.mem");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1) break;
				if (kind == "#") code = $fgets(line, fd);
				else if (kind == "I") begin
					code = $fscanf(fd, "%h %h", a, v);
					imem[a[11:2]] = v;
				end else if (kind == "W") begin
					code = $fscanf(fd, "%d %h", a, v);
					wbRd.push_back(a[4:0]);
					wbVal.push_back(v);
				end else if (kind == "R") begin
					code = $fscanf(fd, "%d %h", a, v);
					finRd.push_back(a[4:0]);
					finVal.push_back(v);
				end else if (kind == "E") code = $fscanf(fd, "%d", expCount);
			end
			$fclose(fd);
		end
	endtask

	task automatic reportTest(input string name, input int errs);
		if (errs == 0) begin
			$display("Test %s: PASS", name);
			passed++;
		end else begin
			$display("Test %s: FAIL (%0d errors)", name, errs);
			failed++;
		end
	endtask

	initial begin
		int          errs;
		logic [11:0] pcHeld;
		logic [31:0] instHeld;
		RSTn = 1'b1; // Reset asserted
		for (int i = 0; i < 1024; i++) imem[i] = {i[9:0], 22'h0}; // Opcode 0, a no-op
		for (int i = 0; i < 4096; i++) dmem[i] <= {i[11:0], 4'h5, ~i[11:0], 4'hA};
		for (int i = 0; i < 32; i++) rf[i] <= 32'd0;
		expCount = 32'd0;
		readTrace();
		cycleLimit = expCount * 32'd10 + 32'd50;

		errs = 0;
		repeat (4) begin
			@(negedge CLK);
			if (iMemAddr != 12'd0 || numInst != 32'd0 || halt || rfWe || !iMemCsn ||
					!dMemCsn || !dMemWen) begin
				$display("[ERROR] %0t: state not cleared during reset", $time);
				errs++;
			end
		end
		RSTn = 1'b0;
		#1;
		// Still idle when the first edge after reset arrives
		if (rfWe || !iMemCsn || !dMemCsn || !dMemWen) begin
			$display("[ERROR] %0t: core active before the first edge after reset", $time);
			errs++;
		end
		@(posedge CLK);
		#1;
		if (iMemAddr != 12'd0 || numInst != 32'd0 || halt || iMemCsn) begin
			$display("[ERROR] %0t: state wrong on first edge after reset", $time);
			errs++;
		end
		reportTest("reset", errs);

		while (!halt) @(negedge CLK);
		if (wbIdx != wbRd.size()) begin
			$display("Only %0d of %0d writebacks seen", wbIdx, wbRd.size());
			wbErrs++;
		end
		reportTest("writebacks", wbErrs);

		errs = 0;
		foreach (finRd[k]) begin
			if (rf[finRd[k]] != finVal[k]) begin
				$display("[ERROR] %0t: x%0d expected %h, got %h", $time, finRd[k],
					finVal[k], rf[finRd[k]]);
				errs++;
			end
		end
		reportTest("branches", errs);
		reportTest("loads", loadErrs);

		errs = 0;
		if (numInst != expCount) begin
			$display("[ERROR] %0t: numInst expected %0d, got %0d", $time, expCount, numInst);
			errs++;
		end
		pcHeld   = iMemAddr;
		instHeld = numInst;
		repeat (5) begin
			@(negedge CLK);
			if (iMemAddr != pcHeld || numInst != instHeld || rfWe || !halt || !iMemCsn ||
					!dMemWen) begin
				$display("[ERROR] %0t: core state moved after halt", $time);
				errs++;
			end
		end
		reportTest("halt", errs);

		$display("Tests: %0d passed, %0d failed", passed, failed);
		if (failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/programTrace.mem ====
# I <byte address hex> <instruction hex> | W <rd decimal> <value hex> | R <reg decimal> <value hex>
# E <expected instruction count decimal> closes the file
I 000 00500093
I 004 FFD00113
I 008 002081B3
I 00C 40208233
I 010 001122B3
I 014 00113333
I 018 40115393
I 01C 12345437
I 020 00001497
I 024 0FF44513
I 028 00108463
I 02C 7FF00593
I 030 00109463
I 034 00100613
I 038 00114463
I 03C 7FF00593
I 040 00116463
I 044 00200693
I 048 0020D463
I 04C 7FF00593
I 050 0020F463
I 054 0080076F
I 058 7FF00593
I 05C 00C707E7
I 060 7FF00593
I 064 10000813
I 068 00882023
I 06C 00A802A3
I 070 00781323
I 074 00082883
I 078 00580903
I 07C 00584983
I 080 00681A03
I 084 00685A83
I 088 00180B03
I 08C 00100073
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 00000008
W 5 00000001
W 6 00000000
W 7 FFFFFFFE
W 8 12345000
W 9 00001020
W 10 123450FF
W 12 00000001
W 13 00000002
W 14 00000058
W 15 00000060
W 16 00000100
W 17 12345000
W 18 FFFFFFFF
W 19 000000FF
W 20 FFFFFFFE
W 21 0000FFFE
W 22 00000050
R 11 00000000
R 12 00000001
R 13 00000002
R 15 00000060
R 17 12345000
E 31

// ==== sources.f ====
hdl/rvIsaPkg.sv
hdl/rvCorePkg.sv
hdl/instrDecoder.sv
hdl/aluUnit.sv
hdl/pcState.sv
hdl/nextPcLogic.sv
hdl/lsuAlign.sv
hdl/RISCV_TOP.sv
dv/riscvTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module riscvTopTb -o simv &&
./obj_dir/simv | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
